//--- common/ctl_defs.svh
`ifndef CTL_DEFS_SVH
`define CTL_DEFS_SVH

// Opcode and function field width
`define CTL_OPCODE_W 6

// Instruction memory latency seen in fetch
`define CTL_FETCH_WAIT 3

// Data memory latency for loads and stores
`define CTL_MEM_WAIT 2

// Exception vector read latency
`define CTL_EXC_WAIT 8

// Wide enough for the longest wait
`define CTL_WAIT_W 4

`endif

//--- common/isa_pkg.sv
`include "ctl_defs.svh"

package isa_pkg;

    // Primary opcodes that the control unit executes
    typedef enum logic [`CTL_OPCODE_W-1:0] {
        op_r_type = 6'h00,
        op_j      = 6'h02,
        op_jal    = 6'h03,
        op_addi   = 6'h08,
        op_addiu  = 6'h09,
        op_lb     = 6'h20,
        op_lh     = 6'h21,
        op_lw     = 6'h23,
        op_sb     = 6'h28,
        op_sh     = 6'h29,
        op_sw     = 6'h2b
    } opcode_e;

    // R-type function codes
    typedef enum logic [`CTL_OPCODE_W-1:0] {
        funct_jr  = 6'h08,
        funct_add = 6'h20,
        funct_sub = 6'h22,
        funct_and = 6'h24
    } funct_e;

    typedef enum logic [3:0] {
        i_add,
        i_and,
        i_sub,
        i_addi,
        i_addiu,
        i_lw,
        i_lh,
        i_lb,
        i_sw,
        i_sh,
        i_sb,
        i_j,
        i_jal,
        i_jr,
        i_illegal
    } instr_e;

endpackage

//--- common/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [5:0] {
        st_init,
        st_fetch_wait,
        st_fetch_latch,
        st_decode,
        st_dispatch,
        st_add,
        st_sub,
        st_and,
        st_addi,
        st_addiu,
        st_wb_rd,
        st_wb_rt,
        st_addr_calc,
        st_mem_wait,
        st_mdr_word,
        st_mdr_half,
        st_mdr_byte,
        st_wb_load,
        st_store_word,
        st_store_half,
        st_store_byte,
        st_jump,
        st_jal,
        st_jal_link,
        st_jr,
        st_exc_illegal,
        st_exc_overflow,
        st_exc_commit
    } state_e;

    typedef enum logic [2:0] {alu_pass, alu_add, alu_and, alu_sub} alu_op_e;

    typedef enum logic [1:0] {alu_a_pc, alu_a_reg_a} alu_a_e;

    typedef enum logic [2:0] {alu_b_reg_b, alu_b_four, alu_b_imm} alu_b_e;

    typedef enum logic [2:0] {
        pc_src_alu_result  = 3'd0,
        pc_src_jump_target = 3'd2,
        pc_src_exc_vector  = 3'd3
    } pc_src_e;

    typedef enum logic [2:0] {iord_pc, iord_alu_out, iord_exc_vector} iord_e;

    typedef enum logic [1:0] {reg_dst_rt, reg_dst_rd, reg_dst_stack, reg_dst_ra} reg_dst_e;

    typedef enum logic [3:0] {
        mem_to_reg_alu_out    = 4'd0,
        mem_to_reg_mdr        = 4'd1,
        mem_to_reg_stack_init = 4'd4
    } mem_to_reg_e;

    // Shared by the MDR load path and the store path from B
    typedef enum logic [1:0] {width_word, width_half, width_byte} width_e;

    typedef enum logic [1:0] {cause_illegal_opcode, cause_overflow} cause_e;

    typedef struct packed {
        logic pc_write;
        logic branch;
        logic ir_write;
        logic a_write;
        logic b_write;
        logic mdr_write;
        logic alu_out_write;
        logic epc_write;
        logic reg_write;
        logic mem_wr;
    } strobes_t;

    typedef struct packed {
        alu_op_e     alu_op;
        alu_a_e      alu_a;
        alu_b_e      alu_b;
        pc_src_e     pc_src;
        iord_e       iord;
        reg_dst_e    reg_dst;
        mem_to_reg_e mem_to_reg;
        width_e      mem_to_mdr;
        width_e      b_to_mem;
        cause_e      except_cause;
    } selects_t;

endpackage

//--- control/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  isa_pkg::opcode_e opcode,
    input  isa_pkg::funct_e  funct,
    output isa_pkg::instr_e  instr_class
);

    always_comb begin
        case (opcode)
            isa_pkg::op_r_type: begin
                case (funct)
                    isa_pkg::funct_add: instr_class = isa_pkg::i_add;
                    isa_pkg::funct_and: instr_class = isa_pkg::i_and;
                    isa_pkg::funct_sub: instr_class = isa_pkg::i_sub;
                    isa_pkg::funct_jr:  instr_class = isa_pkg::i_jr;
                    // Shifts, mult/div, hi/lo moves and the rest
                    default:            instr_class = isa_pkg::i_illegal;
                endcase
            end
            isa_pkg::op_addi:  instr_class = isa_pkg::i_addi;
            isa_pkg::op_addiu: instr_class = isa_pkg::i_addiu;
            isa_pkg::op_lw:    instr_class = isa_pkg::i_lw;
            isa_pkg::op_lh:    instr_class = isa_pkg::i_lh;
            isa_pkg::op_lb:    instr_class = isa_pkg::i_lb;
            isa_pkg::op_sw:    instr_class = isa_pkg::i_sw;
            isa_pkg::op_sh:    instr_class = isa_pkg::i_sh;
            isa_pkg::op_sb:    instr_class = isa_pkg::i_sb;
            isa_pkg::op_j:     instr_class = isa_pkg::i_j;
            isa_pkg::op_jal:   instr_class = isa_pkg::i_jal;
            // lui, branches, slti and unknown codes all trap
            default:           instr_class = isa_pkg::i_illegal;
        endcase
    end

endmodule

//--- control/state_sequencer.sv
`timescale 1ns/1ps
`include "ctl_defs.svh"

module state_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::instr_e  instr_class,
    input  logic             ov,
    output ctrl_pkg::state_e state
);

    ctrl_pkg::state_e       state_next;
    isa_pkg::instr_e        class_q;
    logic [`CTL_WAIT_W-1:0] wait_cnt;
    logic                   fetch_done;
    logic                   mem_done;
    logic                   exc_done;

    assign fetch_done = (wait_cnt == `CTL_WAIT_W'(`CTL_FETCH_WAIT - 1));
    assign mem_done   = (wait_cnt == `CTL_WAIT_W'(`CTL_MEM_WAIT - 1));
    assign exc_done   = (wait_cnt == `CTL_WAIT_W'(`CTL_EXC_WAIT - 1));

    always_comb begin
        case (state)
            ctrl_pkg::st_init:        state_next = ctrl_pkg::st_fetch_wait;
            ctrl_pkg::st_fetch_wait:  state_next = fetch_done ? ctrl_pkg::st_fetch_latch
                                                              : ctrl_pkg::st_fetch_wait;
            ctrl_pkg::st_fetch_latch: state_next = ctrl_pkg::st_decode;
            ctrl_pkg::st_decode:      state_next = ctrl_pkg::st_dispatch;
            ctrl_pkg::st_dispatch: begin
                case (instr_class)
                    isa_pkg::i_add:   state_next = ctrl_pkg::st_add;
                    isa_pkg::i_sub:   state_next = ctrl_pkg::st_sub;
                    isa_pkg::i_and:   state_next = ctrl_pkg::st_and;
                    isa_pkg::i_addi:  state_next = ctrl_pkg::st_addi;
                    isa_pkg::i_addiu: state_next = ctrl_pkg::st_addiu;
                    isa_pkg::i_lw,
                    isa_pkg::i_lh,
                    isa_pkg::i_lb,
                    isa_pkg::i_sw,
                    isa_pkg::i_sh,
                    isa_pkg::i_sb:    state_next = ctrl_pkg::st_addr_calc;
                    isa_pkg::i_j:     state_next = ctrl_pkg::st_jump;
                    isa_pkg::i_jal:   state_next = ctrl_pkg::st_jal;
                    isa_pkg::i_jr:    state_next = ctrl_pkg::st_jr;
                    default:          state_next = ctrl_pkg::st_exc_illegal;
                endcase
            end
            // Signed ops trap on overflow instead of writing back
            ctrl_pkg::st_add,
            ctrl_pkg::st_sub:   state_next = ov ? ctrl_pkg::st_exc_overflow : ctrl_pkg::st_wb_rd;
            ctrl_pkg::st_addi:  state_next = ov ? ctrl_pkg::st_exc_overflow : ctrl_pkg::st_wb_rt;
            ctrl_pkg::st_and:   state_next = ctrl_pkg::st_wb_rd;
            ctrl_pkg::st_addiu: state_next = ctrl_pkg::st_wb_rt;
            ctrl_pkg::st_addr_calc: state_next = ctrl_pkg::st_mem_wait;
            ctrl_pkg::st_mem_wait: begin
                if (!mem_done) begin
                    state_next = ctrl_pkg::st_mem_wait;
                end else begin
                    case (class_q)
                        isa_pkg::i_lw: state_next = ctrl_pkg::st_mdr_word;
                        isa_pkg::i_lh: state_next = ctrl_pkg::st_mdr_half;
                        isa_pkg::i_lb: state_next = ctrl_pkg::st_mdr_byte;
                        isa_pkg::i_sw: state_next = ctrl_pkg::st_store_word;
                        isa_pkg::i_sh: state_next = ctrl_pkg::st_store_half;
                        isa_pkg::i_sb: state_next = ctrl_pkg::st_store_byte;
                        default:       state_next = ctrl_pkg::st_exc_illegal;
                    endcase
                end
            end
            ctrl_pkg::st_mdr_word,
            ctrl_pkg::st_mdr_half,
            ctrl_pkg::st_mdr_byte: state_next = ctrl_pkg::st_wb_load;
            ctrl_pkg::st_jal:      state_next = ctrl_pkg::st_jal_link;
            ctrl_pkg::st_exc_illegal,
            ctrl_pkg::st_exc_overflow: state_next = exc_done ? ctrl_pkg::st_exc_commit : state;
            // Write-back, store, jump and commit states end the instruction
            default: state_next = ctrl_pkg::st_fetch_wait;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctrl_pkg::st_init;
            class_q  <= isa_pkg::i_illegal;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (state_next != state) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (state == ctrl_pkg::st_dispatch) begin
                class_q <= instr_class;
            end
        end
    end

endmodule

//--- control/control_encoder.sv
`timescale 1ns/1ps

module control_encoder (
    input  ctrl_pkg::state_e   state,
    output ctrl_pkg::strobes_t strobes,
    output ctrl_pkg::selects_t selects
);

    always_comb begin
        strobes = '0;
        selects = '0;
        case (state)
            // Stack pointer preset into the register file
            ctrl_pkg::st_init: begin
                strobes.reg_write  = 1'b1;
                selects.reg_dst    = ctrl_pkg::reg_dst_stack;
                selects.mem_to_reg = ctrl_pkg::mem_to_reg_stack_init;
            end
            ctrl_pkg::st_fetch_wait,
            ctrl_pkg::st_fetch_latch: begin
                // PC + 4 on the ALU while the instruction is read
                selects.iord   = ctrl_pkg::iord_pc;
                selects.alu_a  = ctrl_pkg::alu_a_pc;
                selects.alu_b  = ctrl_pkg::alu_b_four;
                selects.alu_op = ctrl_pkg::alu_add;
                if (state == ctrl_pkg::st_fetch_latch) begin
                    strobes.pc_write = 1'b1;
                    strobes.ir_write = 1'b1;
                end
            end
            ctrl_pkg::st_decode: begin
                strobes.a_write = 1'b1;
                strobes.b_write = 1'b1;
            end
            ctrl_pkg::st_add,
            ctrl_pkg::st_sub,
            ctrl_pkg::st_and,
            ctrl_pkg::st_addi,
            ctrl_pkg::st_addiu: begin
                strobes.alu_out_write = 1'b1;
                selects.alu_a         = ctrl_pkg::alu_a_reg_a;
                selects.alu_b         = ctrl_pkg::alu_b_reg_b;
                selects.alu_op        = ctrl_pkg::alu_add;
                if (state == ctrl_pkg::st_sub) begin
                    selects.alu_op = ctrl_pkg::alu_sub;
                end
                if (state == ctrl_pkg::st_and) begin
                    selects.alu_op = ctrl_pkg::alu_and;
                end
                if (state == ctrl_pkg::st_addi || state == ctrl_pkg::st_addiu) begin
                    selects.alu_b = ctrl_pkg::alu_b_imm;
                end
            end
            ctrl_pkg::st_wb_rd,
            ctrl_pkg::st_wb_rt: begin
                strobes.reg_write  = 1'b1;
                selects.mem_to_reg = ctrl_pkg::mem_to_reg_alu_out;
                selects.reg_dst    = (state == ctrl_pkg::st_wb_rd) ? ctrl_pkg::reg_dst_rd
                                                                   : ctrl_pkg::reg_dst_rt;
            end
            ctrl_pkg::st_addr_calc: begin
                selects.alu_a  = ctrl_pkg::alu_a_reg_a;
                selects.alu_b  = ctrl_pkg::alu_b_imm;
                selects.alu_op = ctrl_pkg::alu_add;
            end
            ctrl_pkg::st_mem_wait: selects.iord = ctrl_pkg::iord_alu_out;
            ctrl_pkg::st_mdr_word: begin
                strobes.mdr_write  = 1'b1;
                selects.mem_to_mdr = ctrl_pkg::width_word;
            end
            ctrl_pkg::st_mdr_half: begin
                strobes.mdr_write  = 1'b1;
                selects.mem_to_mdr = ctrl_pkg::width_half;
            end
            ctrl_pkg::st_mdr_byte: begin
                strobes.mdr_write  = 1'b1;
                selects.mem_to_mdr = ctrl_pkg::width_byte;
            end
            ctrl_pkg::st_wb_load: begin
                strobes.reg_write  = 1'b1;
                selects.mem_to_reg = ctrl_pkg::mem_to_reg_mdr;
                selects.reg_dst    = ctrl_pkg::reg_dst_rt;
            end
            ctrl_pkg::st_store_word,
            ctrl_pkg::st_store_half,
            ctrl_pkg::st_store_byte: begin
                strobes.mem_wr   = 1'b1;
                selects.iord     = ctrl_pkg::iord_alu_out;
                selects.b_to_mem = ctrl_pkg::width_word;
                if (state == ctrl_pkg::st_store_half) begin
                    selects.b_to_mem = ctrl_pkg::width_half;
                end
                if (state == ctrl_pkg::st_store_byte) begin
                    selects.b_to_mem = ctrl_pkg::width_byte;
                end
            end
            ctrl_pkg::st_jump: begin
                strobes.pc_write = 1'b1;
                strobes.branch   = 1'b1;
                selects.pc_src   = ctrl_pkg::pc_src_jump_target;
            end
            ctrl_pkg::st_jal: begin
                // Return address is the already incremented PC
                strobes.alu_out_write = 1'b1;
                selects.alu_a         = ctrl_pkg::alu_a_pc;
                selects.alu_op        = ctrl_pkg::alu_pass;
            end
            ctrl_pkg::st_jal_link: begin
                strobes.reg_write  = 1'b1;
                strobes.pc_write   = 1'b1;
                strobes.branch     = 1'b1;
                selects.mem_to_reg = ctrl_pkg::mem_to_reg_alu_out;
                selects.reg_dst    = ctrl_pkg::reg_dst_ra;
                selects.pc_src     = ctrl_pkg::pc_src_jump_target;
            end
            ctrl_pkg::st_jr: begin
                strobes.pc_write = 1'b1;
                strobes.branch   = 1'b1;
                selects.alu_a    = ctrl_pkg::alu_a_reg_a;
                selects.alu_op   = ctrl_pkg::alu_pass;
                selects.pc_src   = ctrl_pkg::pc_src_alu_result;
            end
            ctrl_pkg::st_exc_illegal: begin
                selects.iord         = ctrl_pkg::iord_exc_vector;
                selects.except_cause = ctrl_pkg::cause_illegal_opcode;
            end
            ctrl_pkg::st_exc_overflow: begin
                selects.iord         = ctrl_pkg::iord_exc_vector;
                selects.except_cause = ctrl_pkg::cause_overflow;
            end
            ctrl_pkg::st_exc_commit: begin
                strobes.epc_write = 1'b1;
                strobes.pc_write  = 1'b1;
                selects.pc_src    = ctrl_pkg::pc_src_exc_vector;
            end
            default: begin
                strobes = '0;
                selects = '0;
            end
        endcase
    end

endmodule

//--- verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::opcode_e   opcode,
    input  isa_pkg::funct_e    funct,
    input  logic               ov,
    output ctrl_pkg::strobes_t strobes,
    output ctrl_pkg::selects_t selects
);

    isa_pkg::instr_e  instr_class;
    ctrl_pkg::state_e state;

    instr_decoder u_instr_decoder (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    state_sequencer u_state_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ov          (ov),
        .state       (state)
    );

    // Moore outputs straight from the state
    control_encoder u_control_encoder (
        .state   (state),
        .strobes (strobes),
        .selects (selects)
    );

endmodule

//--- test/tb_control_unit.sv
`timescale 1ns/1ps
`include "ctl_defs.svh"

module tb_control_unit;

    logic               clk = 1'b0;
    logic               reset;
    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    funct;
    logic               ov;
    ctrl_pkg::strobes_t strobes;
    ctrl_pkg::selects_t selects;

    // Instruction memory model, one entry per fetch
    isa_pkg::opcode_e   prog_op[$];
    isa_pkg::funct_e    prog_fn[$];
    isa_pkg::instr_e    prog_cls[$];
    int unsigned        next_idx;

    logic [31:0]        lcg_state;
    logic [31:0]        rnd;
    int unsigned        cycle_count;
    int unsigned        cycle_limit;
    int unsigned        ir_count;
    int unsigned        gap;
    int unsigned        fetch_run;
    int unsigned        alu_cnt;
    int unsigned        reg_cnt;
    int unsigned        mdr_cnt;
    int unsigned        store_cnt;
    int unsigned        redirect_cnt;
    int unsigned        exc_cnt;
    int unsigned        epc_cnt;
    logic               trap;
    logic               reset_seen;
    logic               ir_sampled;
    logic               program_done;
    isa_pkg::instr_e    cur;
    ctrl_pkg::strobes_t init_strobes;

    control_unit u_control_unit (
        .clk     (clk),
        .reset   (reset),
        .opcode  (opcode),
        .funct   (funct),
        .ov      (ov),
        .strobes (strobes),
        .selects (selects)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Cycles from one ir_write to the next
    function automatic int unsigned cycles_for(isa_pkg::instr_e c, logic trapped);
        int unsigned common;
        common = `CTL_FETCH_WAIT + 3;
        if (trapped) begin
            return common + `CTL_EXC_WAIT + 2;
        end
        case (c)
            isa_pkg::i_lw, isa_pkg::i_lh, isa_pkg::i_lb: return common + `CTL_MEM_WAIT + 3;
            isa_pkg::i_sw, isa_pkg::i_sh, isa_pkg::i_sb: return common + `CTL_MEM_WAIT + 2;
            isa_pkg::i_j, isa_pkg::i_jr:                 return common + 1;
            isa_pkg::i_illegal:                          return common + `CTL_EXC_WAIT + 1;
            default:                                     return common + 2;
        endcase
    endfunction

    function automatic ctrl_pkg::alu_op_e alu_op_for(isa_pkg::instr_e c);
        case (c)
            isa_pkg::i_sub: return ctrl_pkg::alu_sub;
            isa_pkg::i_and: return ctrl_pkg::alu_and;
            default:        return ctrl_pkg::alu_add;
        endcase
    endfunction

    function automatic ctrl_pkg::alu_b_e alu_b_for(isa_pkg::instr_e c);
        if (c inside {isa_pkg::i_addi, isa_pkg::i_addiu}) begin
            return ctrl_pkg::alu_b_imm;
        end
        return ctrl_pkg::alu_b_reg_b;
    endfunction

    function automatic ctrl_pkg::reg_dst_e dst_for(isa_pkg::instr_e c);
        if (c inside {isa_pkg::i_addi, isa_pkg::i_addiu, isa_pkg::i_lw, isa_pkg::i_lh,
                      isa_pkg::i_lb}) begin
            return ctrl_pkg::reg_dst_rt;
        end
        return (c == isa_pkg::i_jal) ? ctrl_pkg::reg_dst_ra : ctrl_pkg::reg_dst_rd;
    endfunction

    function automatic ctrl_pkg::width_e width_for(isa_pkg::instr_e c);
        case (c)
            isa_pkg::i_lh, isa_pkg::i_sh: return ctrl_pkg::width_half;
            isa_pkg::i_lb, isa_pkg::i_sb: return ctrl_pkg::width_byte;
            default:                      return ctrl_pkg::width_word;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        report_failure($sformatf("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                                 $time, name, expected, actual));
    endtask

    task automatic check_count(input string name, input int unsigned expected,
                               input int unsigned actual);
        assert (actual == expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic add_entry(input isa_pkg::opcode_e op, input isa_pkg::funct_e fn,
                             input isa_pkg::instr_e cls, input int reps);
        repeat (reps) begin
            prog_op.push_back(op);
            prog_fn.push_back(fn);
            prog_cls.push_back(cls);
        end
    endtask

    task automatic begin_instruction();
        ir_count++;
        if (ir_count > prog_cls.size()) begin
            program_done = 1'b1;
        end else begin
            cur = prog_cls[ir_count-1];
        end
        gap          = 1;
        alu_cnt      = 0;
        reg_cnt      = 0;
        mdr_cnt      = 0;
        store_cnt    = 0;
        redirect_cnt = 0;
        exc_cnt      = 0;
        epc_cnt      = 0;
        trap         = 1'b0;
    endtask

    // Per-cycle checks inside one instruction
    task automatic check_cycle();
        if (strobes.alu_out_write) begin
            alu_cnt++;
            if (cur == isa_pkg::i_jal) begin
                assert (selects.alu_a == ctrl_pkg::alu_a_pc)
                    else report_mismatch("alu_a", 32'(ctrl_pkg::alu_a_pc), 32'(selects.alu_a));
                assert (selects.alu_op == ctrl_pkg::alu_pass)
                    else report_mismatch("alu_op", 32'(ctrl_pkg::alu_pass), 32'(selects.alu_op));
            end else begin
                assert (selects.alu_op == alu_op_for(cur))
                    else report_mismatch("alu_op", 32'(alu_op_for(cur)), 32'(selects.alu_op));
                assert (selects.alu_a == ctrl_pkg::alu_a_reg_a)
                    else report_mismatch("alu_a", 32'(ctrl_pkg::alu_a_reg_a), 32'(selects.alu_a));
                assert (selects.alu_b == alu_b_for(cur))
                    else report_mismatch("alu_b", 32'(alu_b_for(cur)), 32'(selects.alu_b));
                if (cur inside {isa_pkg::i_add, isa_pkg::i_sub, isa_pkg::i_addi}) begin
                    trap = ov;
                end
            end
        end
        if (selects.iord == ctrl_pkg::iord_exc_vector) begin
            exc_cnt++;
            assert (selects.except_cause == (trap ? ctrl_pkg::cause_overflow
                                                  : ctrl_pkg::cause_illegal_opcode))
                else report_mismatch("except_cause", 32'(trap), 32'(selects.except_cause));
        end
        if (strobes.reg_write) begin
            reg_cnt++;
            assert (selects.reg_dst == dst_for(cur))
                else report_mismatch("reg_dst", 32'(dst_for(cur)), 32'(selects.reg_dst));
            if (cur inside {isa_pkg::i_lw, isa_pkg::i_lh, isa_pkg::i_lb}) begin
                check_count("mdr_write before reg_write", 1, mdr_cnt);
                assert (selects.mem_to_reg == ctrl_pkg::mem_to_reg_mdr)
                    else report_mismatch("mem_to_reg", 32'(ctrl_pkg::mem_to_reg_mdr),
                                         32'(selects.mem_to_reg));
            end else begin
                check_count("alu_out_write before reg_write", 1, alu_cnt);
                assert (selects.mem_to_reg == ctrl_pkg::mem_to_reg_alu_out)
                    else report_mismatch("mem_to_reg", 32'(ctrl_pkg::mem_to_reg_alu_out),
                                         32'(selects.mem_to_reg));
            end
        end
        if (strobes.mdr_write) begin
            mdr_cnt++;
            assert (selects.mem_to_mdr == width_for(cur))
                else report_mismatch("mem_to_mdr", 32'(width_for(cur)), 32'(selects.mem_to_mdr));
        end
        if (strobes.mem_wr) begin
            store_cnt++;
            assert (selects.b_to_mem == width_for(cur))
                else report_mismatch("b_to_mem", 32'(width_for(cur)), 32'(selects.b_to_mem));
            assert (selects.iord == ctrl_pkg::iord_alu_out)
                else report_mismatch("iord", 32'(ctrl_pkg::iord_alu_out), 32'(selects.iord));
        end
        if (strobes.epc_write) begin
            epc_cnt++;
            check_count("exception wait cycles", `CTL_EXC_WAIT, exc_cnt);
            assert (strobes.pc_write && selects.pc_src == ctrl_pkg::pc_src_exc_vector)
                else report_mismatch("pc_src", 32'(ctrl_pkg::pc_src_exc_vector),
                                     32'(selects.pc_src));
        end else if (strobes.pc_write) begin
            redirect_cnt++;
            assert (strobes.branch) else report_mismatch("branch", 32'd1, 32'd0);
            assert (selects.pc_src == ((cur == isa_pkg::i_jr) ? ctrl_pkg::pc_src_alu_result
                                                              : ctrl_pkg::pc_src_jump_target))
                else report_mismatch("pc_src", 32'(cur == isa_pkg::i_jr), 32'(selects.pc_src));
        end
    endtask

    task automatic check_instruction_end();
        logic arith;
        logic load;
        logic store;
        logic jump;
        logic excepted;
        arith    = cur inside {isa_pkg::i_add, isa_pkg::i_sub, isa_pkg::i_and,
                               isa_pkg::i_addi, isa_pkg::i_addiu};
        load     = cur inside {isa_pkg::i_lw, isa_pkg::i_lh, isa_pkg::i_lb};
        store    = cur inside {isa_pkg::i_sw, isa_pkg::i_sh, isa_pkg::i_sb};
        jump     = cur inside {isa_pkg::i_j, isa_pkg::i_jr, isa_pkg::i_jal};
        excepted = trap || (cur == isa_pkg::i_illegal);
        check_count("ir_write interval", cycles_for(cur, trap), gap);
        check_count("alu_out_write count", (arith || cur == isa_pkg::i_jal) ? 1 : 0, alu_cnt);
        check_count("reg_write count",
                    ((arith && !trap) || load || cur == isa_pkg::i_jal) ? 1 : 0, reg_cnt);
        check_count("mdr_write count", load ? 1 : 0, mdr_cnt);
        check_count("mem_wr count", store ? 1 : 0, store_cnt);
        check_count("pc redirect count", jump ? 1 : 0, redirect_cnt);
        check_count("epc_write count", excepted ? 1 : 0, epc_cnt);
        check_count("exception wait cycles", excepted ? `CTL_EXC_WAIT : 0, exc_cnt);
    endtask

    // PC + 4 is written together with the instruction
    ir_with_pc: assert property (@(negedge clk) strobes.ir_write |-> strobes.pc_write)
        else report_mismatch("pc_write", 32'd1, 32'(strobes.pc_write));

    decode_after_fetch: assert property (@(negedge clk) disable iff (reset)
        $past(strobes.ir_write) |-> (strobes.a_write && strobes.b_write))
        else report_mismatch("a_write and b_write", 32'd3, 32'({strobes.a_write, strobes.b_write}));

    store_only: assert property (@(negedge clk)
        strobes.mem_wr |-> (cur inside {isa_pkg::i_sw, isa_pkg::i_sh, isa_pkg::i_sb}))
        else report_failure("mem_wr was asserted outside a store instruction");

    // Stimulus lands just after the rising edge
    always @(posedge clk) begin
        #2;
        rnd = next_random();
        ov  = rnd[31];
        if (ir_sampled && next_idx < prog_cls.size()) begin
            opcode = prog_op[next_idx];
            funct  = prog_fn[next_idx];
            next_idx++;
        end
    end

    // Outputs are only sampled mid-cycle
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("Timeout: program not finished within %0d cycles",
                                     cycle_limit));
        end else if (reset || reset_seen) begin
            assert (strobes == init_strobes)
                else report_mismatch("strobes", 32'(init_strobes), 32'(strobes));
            assert (selects.reg_dst == ctrl_pkg::reg_dst_stack)
                else report_mismatch("reg_dst", 32'(ctrl_pkg::reg_dst_stack), 32'(selects.reg_dst));
            assert (selects.mem_to_reg == ctrl_pkg::mem_to_reg_stack_init)
                else report_mismatch("mem_to_reg", 32'(ctrl_pkg::mem_to_reg_stack_init),
                                     32'(selects.mem_to_reg));
        end else if (strobes.ir_write) begin
            check_count("fetch wait cycles", `CTL_FETCH_WAIT, fetch_run);
            if (ir_count > 0) begin
                check_instruction_end();
            end
            begin_instruction();
        end else if (ir_count > 0) begin
            gap++;
            check_cycle();
        end
        if (strobes == '0 && selects.iord == ctrl_pkg::iord_pc &&
            selects.alu_a == ctrl_pkg::alu_a_pc && selects.alu_b == ctrl_pkg::alu_b_four &&
            selects.alu_op == ctrl_pkg::alu_add) begin
            fetch_run++;
        end else begin
            fetch_run = 0;
        end
        reset_seen = reset;
        ir_sampled = strobes.ir_write;
    end

    initial begin
        reset        = 1'b1;
        opcode       = isa_pkg::op_r_type;
        funct        = isa_pkg::funct_add;
        ov           = 1'b0;
        lcg_state    = 32'ha510_576d;
        next_idx     = 0;
        cycle_count  = 0;
        ir_count     = 0;
        gap          = 0;
        fetch_run    = 0;
        trap         = 1'b0;
        reset_seen   = 1'b0;
        ir_sampled   = 1'b0;
        program_done = 1'b0;
        cur          = isa_pkg::i_illegal;
        init_strobes = '0;
        init_strobes.reg_write = 1'b1;

        add_entry(isa_pkg::op_r_type, isa_pkg::funct_add, isa_pkg::i_add, 4);
        add_entry(isa_pkg::op_r_type, isa_pkg::funct_sub, isa_pkg::i_sub, 4);
        add_entry(isa_pkg::op_r_type, isa_pkg::funct_and, isa_pkg::i_and, 3);
        add_entry(isa_pkg::op_addi, isa_pkg::funct_add, isa_pkg::i_addi, 4);
        add_entry(isa_pkg::op_addiu, isa_pkg::funct_add, isa_pkg::i_addiu, 3);
        add_entry(isa_pkg::op_lw, isa_pkg::funct_add, isa_pkg::i_lw, 2);
        add_entry(isa_pkg::op_lh, isa_pkg::funct_add, isa_pkg::i_lh, 2);
        add_entry(isa_pkg::op_lb, isa_pkg::funct_add, isa_pkg::i_lb, 2);
        add_entry(isa_pkg::op_sw, isa_pkg::funct_add, isa_pkg::i_sw, 2);
        add_entry(isa_pkg::op_sh, isa_pkg::funct_add, isa_pkg::i_sh, 2);
        add_entry(isa_pkg::op_sb, isa_pkg::funct_add, isa_pkg::i_sb, 2);
        add_entry(isa_pkg::op_j, isa_pkg::funct_add, isa_pkg::i_j, 2);
        add_entry(isa_pkg::op_r_type, isa_pkg::funct_jr, isa_pkg::i_jr, 2);
        add_entry(isa_pkg::op_jal, isa_pkg::funct_add, isa_pkg::i_jal, 2);
        // lui and beq
        add_entry(isa_pkg::opcode_e'(6'h0f), isa_pkg::funct_add, isa_pkg::i_illegal, 2);
        add_entry(isa_pkg::opcode_e'(6'h04), isa_pkg::funct_add, isa_pkg::i_illegal, 2);

        // Reset, init and first fetch, then every entry at its longest
        cycle_limit = 16 + 1 + `CTL_FETCH_WAIT + 50;
        foreach (prog_cls[i]) begin
            cycle_limit += cycles_for(prog_cls[i],
                prog_cls[i] inside {isa_pkg::i_add, isa_pkg::i_sub, isa_pkg::i_addi});
        end

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        wait (program_done);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
control/instr_decoder.sv
control/state_sequencer.sv
control/control_encoder.sv
verilog/control_unit.sv
test/tb_control_unit.sv

//--- Makefile
TOP = tb_control_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
